// ==== project.f ====
hw/ws2812_pkg.sv
hw/pixel_pkg.sv
hw/pixel_ram_if.sv
hw/pixel_ram.sv
hw/ws2812_bit_enc.sv
hw/ws2812_ctl.sv
hw/ws2812_top.sv
bench/ws2812_tb.sv

// ==== Bender.yml ====
package:
  name: ws2812_driver

# Packages first, then the table interface, the RTL blocks and the top level
sources:
  - hw/ws2812_pkg.sv
  - hw/pixel_pkg.sv
  - hw/pixel_ram_if.sv
  - hw/pixel_ram.sv
  - hw/ws2812_bit_enc.sv
  - hw/ws2812_ctl.sv
  - hw/ws2812_top.sv

  # Self-checking testbench, top module ws2812_tb
  - target: test
    files:
      - bench/ws2812_tb.sv

// ==== bench/ws2812_tb.sv ====
// Self-checking testbench of the WS2812 driver: writes pixel chains, decodes the LED line and compares
`timescale 1ns/100ps

module ws2812_tb
    import ws2812_pkg::*, pixel_pkg::*;
();

    localparam int DRIVE_DLY   = 10;                        // Inputs change this long after posedge
    localparam int CHAIN_LEN   = 8;
    localparam int IDLE_CYCLES = 200;
    localparam int MID_CYCLES  = (T0H_CYCLES + T1H_CYCLES) / 2;
    localparam int GAP_MARK    = RST_CYCLES / 2;            // Low time that separates frames
    localparam int IDLE_MARK   = RST_CYCLES + 3 * BIT_CYCLES;   // Controller surely back in idle
    localparam int FRAME_LEDS  = 1 + CHAIN_LEN + CHAIN_LEN + 2 * CHAIN_LEN;
    localparam int FRAMES      = 5;
    localparam int WATCHDOG_CYCLES =
        2 * (FRAME_LEDS * BIT_CYCLES * COLOR_BITS + FRAMES * RST_CYCLES + IDLE_CYCLES);
    localparam int FRAME_LIMIT = DEPTH * COLOR_BITS * (BIT_CYCLES + 4) + 2 * RST_CYCLES;

    logic                    clk_in;
    logic                    rst_n_in;
    logic                    wr_en;
    logic [ADDR_W-1:0]       wr_addr;
    logic [LANES-1:0]        byte_en;
    logic [WORD_W/LANES-1:0] byte_data;
    logic                    frame_rdy;
    logic                    led_dout;

    logic [WORD_W-1:0]  shadow [DEPTH];                     // Mirror of the pixel table
    logic [ADDR_W-1:0]  chain_addr [CHAIN_LEN];
    logic [15:0]        lfsr_q;
    logic [COLOR_W-1:0] exp_q [$];
    logic [COLOR_W-1:0] got_q [$];
    int                 gaps [$];                           // Low time after each frame
    int                 frames_done;
    int                 errors;
    int                 tests_passed;
    int                 tests_failed;
    string              cur_test;

    ws2812_top ws2812_top_i (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .byte_en   (byte_en),
        .byte_data (byte_data),
        .frame_rdy (frame_rdy),
        .led_dout  (led_dout)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // Helpers --------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // Expected colors, walked from entry 0 along the next fields
    function automatic int ref_walk(output logic [COLOR_W-1:0] colors [DEPTH]);
        logic [ADDR_W-1:0] addr;
        int                n;
        addr = '0;
        n    = 0;
        do begin
            colors[n] = shadow[addr][COLOR_W-1:0];
            n++;
            addr = shadow[addr][NEXT_LSB +: NEXT_W];
        end while (addr != '0 && n < DEPTH);
        return n;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic step();
        @(posedge clk_in);
        #DRIVE_DLY;
    endtask

    task automatic write_byte(input logic [ADDR_W-1:0] addr, input logic [LANES-1:0] lanes,
                              input logic [7:0] data);
        for (int i = 0; i < LANES; i++) begin
            if (lanes[i]) shadow[addr][i*8 +: 8] = data;
        end
        wr_en     = 1'b1;
        wr_addr   = addr;
        byte_en   = lanes;
        byte_data = data;
        step();
        wr_en     = 1'b0;
    endtask

    task automatic write_entry(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] word);
        for (int i = 0; i < LANES; i++) begin
            write_byte(addr, LANES'(1 << i), word[i*8 +: 8]);
        end
    endtask

    task automatic expect_frame();
        logic [COLOR_W-1:0] colors [DEPTH];
        int                 n;
        n = ref_walk(colors);
        for (int i = 0; i < n; i++) exp_q.push_back(colors[i]);
    endtask

    task automatic wait_frames(input int target);
        int waited;
        waited = 0;
        while (frames_done < target && waited < FRAME_LIMIT) begin
            step();
            waited++;
        end
        if (frames_done < target) begin
            $display("%s: frame on the LED line did not finish in %0d cycles", cur_test, waited);
            errors++;
        end
    endtask

    task automatic run_frame();
        int base;
        base      = frames_done;
        frame_rdy = 1'b1;
        step();
        frame_rdy = 1'b0;
        wait_frames(base + 1);
    endtask

    task automatic finish_test(input int err_before);
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected LED colors never showed up", cur_test, exp_q.size());
            errors++;
            exp_q.delete();
        end
        if (errors == err_before) begin
            tests_passed++;
            $display("%-14s passed", cur_test);
        end else begin
            tests_failed++;
            $display("%-14s failed with %0d errors", cur_test, errors - err_before);
        end
    endtask

    // Line decoder --------------------
    logic               line_q;
    logic               frame_open;
    int                 high_cnt;
    int                 low_cnt;
    int                 bit_cnt;
    logic [COLOR_W-1:0] shift_q;

    task automatic close_frame(input int gap);
        if (bit_cnt != 0) begin
            $display("%s: frame ended with %0d stray bits", cur_test, bit_cnt);
            errors++;
        end
        bit_cnt    = 0;
        frame_open = 1'b0;
        gaps.push_back(gap);
        frames_done++;
    endtask

    always @(negedge clk_in) begin                          // Sampled away from DUT edges
        if (!rst_n_in) begin
            line_q     = 1'b0;
            frame_open = 1'b0;
            high_cnt   = 0;
            low_cnt    = 0;
            bit_cnt    = 0;
        end else if (led_dout) begin
            if (!line_q) begin
                if (frame_open && low_cnt >= GAP_MARK) close_frame(low_cnt);
                frame_open = 1'b1;
                high_cnt   = 0;
            end
            high_cnt++;
            line_q = 1'b1;
        end else begin
            if (line_q) begin                               // End of a high pulse
                shift_q = {shift_q[COLOR_W-2:0], high_cnt > MID_CYCLES};
                bit_cnt++;
                if (bit_cnt == COLOR_BITS) begin
                    got_q.push_back(shift_q);
                    bit_cnt = 0;
                end
                low_cnt = 0;
            end
            low_cnt++;
            if (frame_open && low_cnt == IDLE_MARK) close_frame(low_cnt);
            line_q = 1'b0;
        end
    end

    // Compares each decoded color with the next expected one
    always @(posedge clk_in) begin
        if (got_q.size() != 0) begin
            if (exp_q.size() == 0) begin
                $display("%s: LED color %h arrived with none expected", cur_test, got_q[0]);
                errors++;
                void'(got_q.pop_front());
            end else begin
                check_equal(cur_test, exp_q.pop_front(), got_q.pop_front());
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("Run timed out after %0d cycles without finishing all tests", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // Test sequence --------------------
    initial begin
        int                 err_before;
        int                 base;
        int                 highs;
        int                 idx;
        logic [ADDR_W-1:0]  cand;
        logic [ADDR_W-1:0]  next;
        logic               used [DEPTH];

        rst_n_in     = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        byte_en      = '0;
        byte_data    = '0;
        frame_rdy    = 1'b0;
        lfsr_q       = 16'd75;
        frames_done  = 0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test     = "reset";
        for (int i = 0; i < DEPTH; i++) begin
            shadow[i] = '0;
            used[i]   = 1'b0;
        end
        repeat (3) @(posedge clk_in);
        #DRIVE_DLY;
        rst_n_in = 1'b1;

        cur_test   = "idle_line";
        err_before = errors;
        highs      = 0;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            step();
            if (led_dout !== 1'b0) highs++;
        end
        check_equal(cur_test, 0, highs);
        finish_test(err_before);

        cur_test   = "single_led";
        err_before = errors;
        write_entry(0, {8'h00, COLOR_W'(random_bits(COLOR_W))});
        expect_frame();
        run_frame();
        finish_test(err_before);

        // Entry 0 heads the chain, the rest are distinct and not consecutive
        cur_test      = "chain";
        err_before    = errors;
        chain_addr[0] = '0;
        used[0]       = 1'b1;
        for (int i = 1; i < CHAIN_LEN; i++) begin
            do begin
                cand = ADDR_W'(random_bits(ADDR_W));
            end while (used[cand] || cand == chain_addr[i-1] + 1'b1);
            used[cand]    = 1'b1;
            chain_addr[i] = cand;
        end
        for (int i = 0; i < CHAIN_LEN; i++) begin
            next = (i == CHAIN_LEN - 1) ? '0 : chain_addr[i+1];
            write_entry(chain_addr[i], {2'b00, next, COLOR_W'(random_bits(COLOR_W))});
        end
        expect_frame();
        run_frame();
        finish_test(err_before);

        cur_test   = "byte_lanes";
        err_before = errors;
        for (int k = 0; k < 2; k++) begin
            idx = int'(random_bits(3));
            write_byte(chain_addr[idx], LANES'(1 << (random_bits(2) % 3)), random_bits(8));
        end
        expect_frame();
        run_frame();
        finish_test(err_before);

        cur_test   = "repeat_frames";
        err_before = errors;
        expect_frame();
        expect_frame();
        base      = frames_done;
        frame_rdy = 1'b1;
        wait_frames(base + 1);                              // Second frame has begun
        frame_rdy = 1'b0;
        wait_frames(base + 2);
        if (gaps.size() > base && gaps[base] < RST_CYCLES) begin
            $display("%s: gap between frames is %0d cycles, shorter than %0d",
                     cur_test, gaps[base], RST_CYCLES);
            errors++;
        end
        finish_test(err_before);

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/ws2812_top.sv ====
// Top level of the WS2812 LED driver: host write port and frame strobe in, one LED data line out
`timescale 1ns/100ps

module ws2812_top
    import pixel_pkg::*;
(
    input  logic                    clk_in,
    input  logic                    rst_n_in,

    // Host table writes
    input  logic                    wr_en,
    input  logic [ADDR_W-1:0]       wr_addr,
    input  logic [LANES-1:0]        byte_en,
    input  logic [WORD_W/LANES-1:0] byte_data,

    input  logic                    frame_rdy,   // Level, sampled while idle
    output logic                    led_dout
);

    logic bit_rdy;
    logic bit_data;
    logic bit_done;

    ws2812_ctl ws2812_ctl_i (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .byte_en   (byte_en),
        .byte_data (byte_data),
        .frame_rdy (frame_rdy),
        .bit_done  (bit_done),
        .bit_rdy   (bit_rdy),
        .bit_data  (bit_data)
    );

    ws2812_bit_enc ws2812_bit_enc_i (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .bit_rdy   (bit_rdy),
        .bit_data  (bit_data),
        .bit_done  (bit_done),
        .led_dout  (led_dout)
    );

endmodule

// ==== hw/ws2812_ctl.sv ====
// Frame controller in the LED driver top that walks the pixel chain and feeds bits to the encoder
`timescale 1ns/100ps

module ws2812_ctl
    import ws2812_pkg::*, pixel_pkg::*;
(
    input  logic                    clk_in,
    input  logic                    rst_n_in,

    input  logic                    wr_en,
    input  logic [ADDR_W-1:0]       wr_addr,
    input  logic [LANES-1:0]        byte_en,
    input  logic [WORD_W/LANES-1:0] byte_data,

    input  logic                    frame_rdy,
    input  logic                    bit_done,

    output logic                    bit_rdy,
    output logic                    bit_data
);

    typedef logic [$clog2(COLOR_BITS)-1:0] bit_idx_t;
    typedef logic [$clog2(RST_CYCLES)-1:0] rst_cnt_t;

    ctl_state_t        state;
    logic [ADDR_W-1:0] cur_addr;           // Entry being fetched
    bit_idx_t          bit_idx;            // Color bit on the line from 23 down to 0
    rst_cnt_t          rst_cnt;
    logic              rd_valid_q;         // rd_q holds the fetched entry
    logic              bit_busy;           // Encoder is shaping a bit

    logic              rd_lvl;
    logic              rd_lvl_q;
    logic              bit_lvl;
    logic              bit_lvl_q;

    logic [COLOR_W-1:0] color_q;
    logic [NEXT_W-1:0]  next_q;

    pixel_ram_if ram_if ();

    pixel_ram pixel_ram_i (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .mem      (ram_if.mem)
    );

    // Host writes go straight to the table
    assign ram_if.wr_en     = wr_en;
    assign ram_if.wr_addr   = wr_addr;
    assign ram_if.byte_en   = byte_en;
    assign ram_if.byte_data = byte_data;

    // Strobes --------------------
    // Rising edges of the two request levels give one-cycle strobes
    assign rd_lvl         = (state == st_read_entry);
    assign bit_lvl        = (state == st_send_bit) && !bit_busy;
    assign ram_if.rd_en   = rd_lvl && !rd_lvl_q;
    assign ram_if.rd_addr = cur_addr;
    assign bit_rdy        = bit_lvl && !bit_lvl_q;
    assign bit_data       = color_q[bit_idx];   // Held while the encoder works

    // FSM --------------------
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            state      <= st_idle;
            cur_addr   <= '0;
            bit_idx    <= '0;
            rst_cnt    <= '0;
            rd_valid_q <= 1'b0;
            bit_busy   <= 1'b0;
            rd_lvl_q   <= 1'b0;
            bit_lvl_q  <= 1'b0;
        end else begin
            rd_lvl_q   <= rd_lvl;
            bit_lvl_q  <= bit_lvl;
            rd_valid_q <= ram_if.rd_en;

            if (bit_rdy) begin
                bit_busy <= 1'b1;
            end else if (bit_done) begin
                bit_busy <= 1'b0;
            end

            case (state)
                st_idle: begin
                    if (frame_rdy) begin             // Chain always starts at entry 0
                        cur_addr <= '0;
                        state    <= st_read_entry;
                    end
                end
                st_read_entry: begin
                    if (rd_valid_q) begin
                        bit_idx <= bit_idx_t'(COLOR_BITS - 1);
                        state   <= st_send_bit;
                    end
                end
                st_send_bit: begin
                    if (bit_done) begin
                        if (bit_idx != '0) begin
                            bit_idx <= bit_idx - 1'b1;
                        end else if (next_q == '0) begin
                            rst_cnt <= '0;
                            state   <= st_send_rst;     // Last LED of the chain
                        end else begin
                            cur_addr <= next_q;
                            state    <= st_read_entry;
                        end
                    end
                end
                st_send_rst: begin
                    if (rst_cnt == rst_cnt_t'(RST_CYCLES - 1)) begin
                        state <= st_idle;
                    end else begin
                        rst_cnt <= rst_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Fields of the fetched entry
    always_ff @(posedge clk_in) begin
        if ((state == st_read_entry) && rd_valid_q) begin
            color_q <= ram_if.rd_q[COLOR_W-1:0];
            next_q  <= ram_if.rd_q[NEXT_LSB +: NEXT_W];
        end
    end

    // Assertions --------------------
    a_state_legal: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        state inside {st_idle, st_read_entry, st_send_bit, st_send_rst}
    ) else $error("ws2812_ctl in illegal state %0d", state);

    // A bit strobe belongs to send_bit and the encoder cannot end the bit it just got
    a_bit_rdy_in_send: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        bit_rdy |=> (state == st_send_bit)
    ) else $error("ws2812_ctl left send_bit as a bit started, state %s", state.name());

    a_bit_idx_range: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        int'(bit_idx) <= COLOR_BITS - 1
    ) else $error("ws2812_ctl bit index %0d out of range", bit_idx);

endmodule

// ==== hw/ws2812_bit_enc.sv ====
// Bit encoder of the LED driver: turns one bit strobe into a timed WS2812 high/low pulse on the line
`timescale 1ns/100ps

module ws2812_bit_enc
    import ws2812_pkg::*;
(
    input  logic clk_in,
    input  logic rst_n_in,
    input  logic bit_rdy,
    input  logic bit_data,
    output logic bit_done,
    output logic led_dout
);

    typedef logic [$clog2(BIT_CYCLES)-1:0] per_cnt_t;

    logic     busy_q;                      // A bit period is running
    per_cnt_t cnt_q;                       // Cycle within the period
    logic     bit_q;                       // Value of the bit being sent
    logic     period_end;
    logic     high_end;

    assign period_end = busy_q && (cnt_q == per_cnt_t'(BIT_CYCLES - 1));
    assign bit_done   = period_end;

    // The line drops once the next cycle reaches the high time of the latched bit
    assign high_end = (int'(cnt_q) + 1) >= (bit_q ? T1H_CYCLES : T0H_CYCLES);

    // Period counter --------------------
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            busy_q   <= 1'b0;
            cnt_q    <= '0;
            bit_q    <= 1'b0;
            led_dout <= 1'b0;
        end else if (bit_rdy) begin
            busy_q   <= 1'b1;
            cnt_q    <= '0;
            bit_q    <= bit_data;
            led_dout <= 1'b1;              // Line rises the cycle after the strobe
        end else if (busy_q) begin
            led_dout <= led_dout && !high_end;
            if (period_end) begin
                busy_q <= 1'b0;
                cnt_q  <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Assertions --------------------
    // The controller waits for bit_done before it strobes again
    a_no_overlap: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        bit_rdy |-> !busy_q
    ) else $error("ws2812_bit_enc got bit_rdy while busy");

endmodule

// ==== hw/pixel_ram.sv ====
// Pixel table of the LED driver, written one byte lane at a time and read through a registered port
`timescale 1ns/100ps

module pixel_ram
    import pixel_pkg::*;
(
    input logic        clk_in,
    input logic        rst_n_in,
    pixel_ram_if.mem   mem
);

    logic [WORD_W-1:0] entry_q [DEPTH];    // Entry storage, no reset

    // Write port --------------------
    always_ff @(posedge clk_in) begin
        if (mem.wr_en) begin
            for (int i = 0; i < LANES; i++) begin
                if (mem.byte_en[i]) begin
                    entry_q[mem.wr_addr][i*(WORD_W/LANES) +: WORD_W/LANES] <= mem.byte_data;
                end
            end
        end
    end

    // Read port --------------------
    // A write and a read at the same edge give the old word, a later read the new one
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            mem.rd_q <= '0;
        end else if (mem.rd_en) begin
            mem.rd_q <= entry_q[mem.rd_addr];
        end
    end

    // Assertions --------------------
    a_rd_addr_known: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        mem.rd_en |-> !$isunknown(mem.rd_addr)
    ) else $error("pixel_ram read with unknown address");

endmodule

// ==== hw/pixel_ram_if.sv ====
// Write and read signals of the pixel table, shared by the frame controller and the table itself
`timescale 1ns/100ps

interface pixel_ram_if
    import pixel_pkg::*;
();

    logic                    wr_en;        // One-cycle host write strobe
    logic [ADDR_W-1:0]       wr_addr;
    logic [LANES-1:0]        byte_en;      // Lanes that take byte_data
    logic [WORD_W/LANES-1:0] byte_data;
    logic                    rd_en;        // One-cycle read strobe
    logic [ADDR_W-1:0]       rd_addr;
    logic [WORD_W-1:0]       rd_q;         // Valid the cycle after rd_en

    // Side that issues writes and reads
    modport owner (
        output wr_en, wr_addr, byte_en, byte_data,
        output rd_en, rd_addr,
        input  rd_q
    );

    // Side that stores the entries
    modport mem (
        input  wr_en, wr_addr, byte_en, byte_data,
        input  rd_en, rd_addr,
        output rd_q
    );

endinterface

// ==== hw/pixel_pkg.sv ====
// Pixel table geometry and entry field layout, imported by the table, its interface and the controller

package pixel_pkg;

    // Table geometry --------------------
    localparam int ADDR_W = 6;             // Entry address width
    localparam int DEPTH  = 64;            // Number of entries
    localparam int WORD_W = 32;            // Bits per entry
    localparam int LANES  = 4;             // Byte lanes per entry

    // Entry fields --------------------
    // Bits 31..30 of an entry are unused
    localparam int NEXT_LSB = 24;          // Low bit of the next address
    localparam int NEXT_W   = 6;           // Width of the next address
    localparam int COLOR_W  = 24;          // GRB color in the low bits

endpackage

// ==== hw/ws2812_pkg.sv ====
// WS2812 line timing in clock cycles and the frame controller state type, imported by the LED driver blocks

package ws2812_pkg;

    // Line timing --------------------
    // Counts assume a 10 MHz clock
    localparam int T0H_CYCLES = 4;         // High time of a 0 bit, 0.4 us
    localparam int T1H_CYCLES = 8;         // High time of a 1 bit, 0.8 us
    localparam int BIT_CYCLES = 13;        // Whole bit period, 1.3 us
    localparam int RST_CYCLES = 500;       // Low time after a frame, 50 us

    // Frame format --------------------
    localparam int COLOR_BITS = 24;        // GRB bits per LED, sent MSB first

    // Frame controller states --------------------
    typedef enum logic [1:0] {
        st_idle,                           // Waiting for frame_rdy
        st_read_entry,                     // Fetching one table entry
        st_send_bit,                       // Shifting out the 24 color bits
        st_send_rst                        // Holding the line low after the frame
    } ctl_state_t;

endpackage
